/* pcw_pkg.sv */
//********************************************************************
// PCW system control definitions
//********************************************************************
`default_nettype none

package pcw_pkg;

    // RAM address is a bank number above a 16K offset
    localparam int BANK_W   = 4;
    localparam int OFFSET_W = 14;

    // Bus and address types
    typedef logic [15:0]                cpu_addr_t;
    typedef logic [7:0]                 cpu_data_t;
    typedef logic [BANK_W+OFFSET_W-1:0] ram_addr_t;
    typedef logic [BANK_W-1:0]          bank_t;

    // Missed 300 Hz ticks, saturates at 15
    typedef logic [3:0] miss_count_t;

    // I/O port numbers, low address byte
    localparam logic [7:0] PORT_PAGE0      = 8'hF0;
    localparam logic [7:0] PORT_PAGE1      = 8'hF1;
    localparam logic [7:0] PORT_PAGE2      = 8'hF2;
    localparam logic [7:0] PORT_PAGE3      = 8'hF3;
    localparam logic [7:0] PORT_CPC_LOCK   = 8'hF4;
    localparam logic [7:0] PORT_ROLLER     = 8'hF5;
    localparam logic [7:0] PORT_YSCROLL    = 8'hF6;
    localparam logic [7:0] PORT_VIDEO_CTRL = 8'hF7;
    localparam logic [7:0] PORT_SYS_CTRL   = 8'hF8;

    // System control commands, low nibble of an F8 write
    localparam logic [3:0] CMD_DISK_NMI  = 4'd2;
    localparam logic [3:0] CMD_DISK_INT  = 4'd3;
    localparam logic [3:0] CMD_DISK_OFF  = 4'd4;
    localparam logic [3:0] CMD_TC_SET    = 4'd5;
    localparam logic [3:0] CMD_TC_CLR    = 4'd6;
    localparam logic [3:0] CMD_MOTOR_ON  = 4'd9;
    localparam logic [3:0] CMD_MOTOR_OFF = 4'd10;
    localparam logic [3:0] CMD_SPK_ON    = 4'd11;
    localparam logic [3:0] CMD_SPK_OFF   = 4'd12;

    // Power-up register contents, PCW mode banks 0 to 3
    localparam cpu_data_t PAGE0_RESET      = 8'h80;
    localparam cpu_data_t PAGE1_RESET      = 8'h81;
    localparam cpu_data_t PAGE2_RESET      = 8'h82;
    localparam cpu_data_t PAGE3_RESET      = 8'h83;
    localparam cpu_data_t CPC_LOCK_RESET   = 8'hF1;
    localparam cpu_data_t VIDEO_CTRL_RESET = 8'h80;

    // Delay from a timer acknowledge to the clear of the miss count
    localparam int TIMER_CLEAR_CYCLES = 32;
    typedef logic [$clog2(TIMER_CLEAR_CYCLES)-1:0] clear_count_t;

    // Unmapped I/O reads float high
    localparam cpu_data_t IO_READ_DEFAULT = 8'hFF;

endpackage

`default_nettype wire

/* pcw_port_regs.sv */
//********************************************************************
// I/O port registers F0 to F8
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_port_regs (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire                     io_wr,
    input  wire pcw_pkg::cpu_addr_t cpu_addr,
    input  wire pcw_pkg::cpu_data_t cpu_dout,
    output pcw_pkg::cpu_data_t      page0,
    output pcw_pkg::cpu_data_t      page1,
    output pcw_pkg::cpu_data_t      page2,
    output pcw_pkg::cpu_data_t      page3,
    output pcw_pkg::cpu_data_t      cpc_lock,
    output pcw_pkg::cpu_data_t      roller_ptr,
    output pcw_pkg::cpu_data_t      yscroll,
    output logic                    inverse,
    output logic                    disable_vid,
    output logic                    disk_to_nmi,
    output logic                    disk_to_int,
    output logic                    int_mode_change,
    output logic                    fdc_tc,
    output logic                    motor,
    output logic                    speaker_enable
);

    // Only bits 7:6 of port F7 have a meaning
    logic [1:0] video_ctrl;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            page0           <= pcw_pkg::PAGE0_RESET;
            page1           <= pcw_pkg::PAGE1_RESET;
            page2           <= pcw_pkg::PAGE2_RESET;
            page3           <= pcw_pkg::PAGE3_RESET;
            cpc_lock        <= pcw_pkg::CPC_LOCK_RESET;
            roller_ptr      <= '0;
            yscroll         <= '0;
            video_ctrl      <= pcw_pkg::VIDEO_CTRL_RESET[7:6];
            disk_to_nmi     <= 1'b0;
            disk_to_int     <= 1'b0;
            int_mode_change <= 1'b0;
            fdc_tc          <= 1'b0;
            motor           <= 1'b0;
            speaker_enable  <= 1'b0;
        end
        else
        begin
            // Mode change is a single-cycle pulse
            int_mode_change <= 1'b0;
            if (io_wr)
            begin
                // Only the low address byte selects the port
                case (cpu_addr[7:0])
                    pcw_pkg::PORT_PAGE0:      page0      <= cpu_dout;
                    pcw_pkg::PORT_PAGE1:      page1      <= cpu_dout;
                    pcw_pkg::PORT_PAGE2:      page2      <= cpu_dout;
                    pcw_pkg::PORT_PAGE3:      page3      <= cpu_dout;
                    pcw_pkg::PORT_CPC_LOCK:   cpc_lock   <= cpu_dout;
                    pcw_pkg::PORT_ROLLER:     roller_ptr <= cpu_dout;
                    pcw_pkg::PORT_YSCROLL:    yscroll    <= cpu_dout;
                    pcw_pkg::PORT_VIDEO_CTRL: video_ctrl <= cpu_dout[7:6];
                    pcw_pkg::PORT_SYS_CTRL:
                    begin
                        // Command in the low nibble, other codes are ignored
                        case (cpu_dout[3:0])
                            pcw_pkg::CMD_DISK_NMI:
                            begin
                                // No mode change pulse for NMI routing
                                disk_to_nmi <= 1'b1;
                                disk_to_int <= 1'b0;
                            end
                            pcw_pkg::CMD_DISK_INT:
                            begin
                                disk_to_nmi     <= 1'b0;
                                disk_to_int     <= 1'b1;
                                int_mode_change <= 1'b1;
                            end
                            pcw_pkg::CMD_DISK_OFF:
                            begin
                                disk_to_nmi     <= 1'b0;
                                disk_to_int     <= 1'b0;
                                int_mode_change <= 1'b1;
                            end
                            pcw_pkg::CMD_TC_SET:    fdc_tc         <= 1'b1;
                            pcw_pkg::CMD_TC_CLR:    fdc_tc         <= 1'b0;
                            pcw_pkg::CMD_MOTOR_ON:  motor          <= 1'b1;
                            pcw_pkg::CMD_MOTOR_OFF: motor          <= 1'b0;
                            pcw_pkg::CMD_SPK_ON:    speaker_enable <= 1'b1;
                            pcw_pkg::CMD_SPK_OFF:   speaker_enable <= 1'b0;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // F7 bit 7 inverts video, bit 6 set enables it
    assign inverse     = video_ctrl[1];
    assign disable_vid = ~video_ctrl[0];

endmodule

`default_nettype wire

/* pcw_page_mapper.sv */
//********************************************************************
// PCW and CPC memory paging
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_page_mapper (
    input  wire pcw_pkg::cpu_addr_t cpu_addr,
    input  wire                     mem_wr,
    input  wire pcw_pkg::cpu_data_t page0,
    input  wire pcw_pkg::cpu_data_t page1,
    input  wire pcw_pkg::cpu_data_t page2,
    input  wire pcw_pkg::cpu_data_t page3,
    input  wire pcw_pkg::cpu_data_t cpc_lock,
    output pcw_pkg::ram_addr_t      ram_addr
);

    // 16K slot picked by the top two address bits
    logic [1:0]         slot;
    pcw_pkg::cpu_data_t page_sel;
    // Per-slot read lock, CPC mode only
    logic [3:0]         read_lock;
    pcw_pkg::bank_t     bank;

    assign slot      = cpu_addr[15:14];
    assign read_lock = cpc_lock[7:4];

    always_comb
    begin
        case (slot)
            2'd0:    page_sel = page0;
            2'd1:    page_sel = page1;
            2'd2:    page_sel = page2;
            default: page_sel = page3;
        endcase
    end

    always_comb
    begin
        if (page_sel[7])
            // PCW mode, one bank for reads and writes
            bank = page_sel[3:0];
        else if (mem_wr || read_lock[slot])
            // CPC write bank, also read when the slot is locked
            bank = {1'b0, page_sel[2:0]};
        else
            // CPC read bank
            bank = {1'b0, page_sel[6:4]};
    end

    assign ram_addr = {bank, cpu_addr[pcw_pkg::OFFSET_W-1:0]};

endmodule

`default_nettype wire

/* pcw_int_ctrl.sv */
//********************************************************************
// Timer and disk interrupt control
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_int_ctrl (
    input  wire                  clk_sys,
    input  wire                  reset,
    input  wire                  vid_timer,
    input  wire                  fdc_int,
    input  wire                  iff1,
    input  wire                  timer_ack,
    input  wire                  disk_to_nmi,
    input  wire                  disk_to_int,
    input  wire                  int_mode_change,
    output pcw_pkg::miss_count_t timer_misses,
    output logic                 fdc_status,
    output logic                 nmi_n,
    output logic                 int_n
);

    // Previous input levels for edge detection
    logic timer_d;
    logic fdc_d;
    // Registered 300 Hz tick
    logic timer_tick;
    logic fdc_rise;
    logic fdc_fall;

    // Latched interrupt state
    logic nmi_flag;
    logic nmi_line;
    logic int_line;
    logic timer_line;

    // Delayed clear after a timer acknowledge
    logic                  clear_active;
    pcw_pkg::clear_count_t clear_count;

    assign fdc_rise = fdc_int & ~fdc_d;
    assign fdc_fall = ~fdc_int & fdc_d;

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            timer_d      <= 1'b0;
            fdc_d        <= 1'b0;
            timer_tick   <= 1'b0;
            fdc_status   <= 1'b0;
            nmi_flag     <= 1'b0;
            nmi_line     <= 1'b0;
            int_line     <= 1'b0;
            timer_line   <= 1'b0;
            timer_misses <= '0;
            clear_active <= 1'b0;
            clear_count  <= '0;
        end
        else
        begin
            timer_d    <= vid_timer;
            fdc_d      <= fdc_int;
            timer_tick <= vid_timer & ~timer_d;

            // FDC status follows the interrupt edges
            if (fdc_rise)
            begin
                fdc_status <= 1'b1;
                if (disk_to_nmi)
                    nmi_flag <= 1'b1;
            end
            else if (fdc_fall)
                fdc_status <= 1'b0;

            // All lines are sampled on the tick
            if (timer_tick)
            begin
                if (timer_misses != '1)
                    timer_misses <= timer_misses + 1'b1;
                timer_line <= iff1;
                nmi_line   <= nmi_flag;
                int_line   <= disk_to_int & fdc_status & iff1;
            end

            // Routing change drops stale disk requests
            if (int_mode_change)
            begin
                if (disk_to_int)
                    nmi_flag <= 1'b0;
                else if (!disk_to_nmi)
                begin
                    nmi_flag <= 1'b0;
                    int_line <= 1'b0;
                end
            end

            // Clear count and timer line at the end of the delay
            if (clear_active)
            begin
                if (clear_count == pcw_pkg::clear_count_t'(pcw_pkg::TIMER_CLEAR_CYCLES - 1))
                begin
                    clear_active <= 1'b0;
                    timer_line   <= 1'b0;
                    timer_misses <= '0;
                end
                else
                    clear_count <= clear_count + 1'b1;
            end
            // A new acknowledge restarts the delay
            if (timer_ack)
            begin
                clear_active <= 1'b1;
                clear_count  <= '0;
            end
        end
    end

    assign nmi_n = ~nmi_line;
    // INT held off while an NMI is outstanding
    assign int_n = nmi_line | ~(int_line | timer_line);

endmodule

`default_nettype wire

/* pcw_bus_read_mux.sv */
//********************************************************************
// CPU read data select
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_bus_read_mux (
    input  wire                      io_rd,
    input  wire pcw_pkg::cpu_addr_t  cpu_addr,
    input  wire pcw_pkg::cpu_data_t  ram_dout,
    input  wire pcw_pkg::miss_count_t timer_misses,
    input  wire                      fdc_status,
    input  wire                      vblank,
    input  wire                      ntsc,
    output pcw_pkg::cpu_data_t       cpu_din,
    output logic                     timer_ack
);

    // Status byte: 0, vblank, FDC, not NTSC, miss count
    pcw_pkg::cpu_data_t status;

    assign status = {1'b0, vblank, fdc_status, ~ntsc, timer_misses};

    // Reading F4 acknowledges the timer
    assign timer_ack = io_rd && (cpu_addr[7:0] == pcw_pkg::PORT_CPC_LOCK);

    always_comb
    begin
        if (io_rd)
        begin
            case (cpu_addr[7:0])
                pcw_pkg::PORT_SYS_CTRL,
                pcw_pkg::PORT_CPC_LOCK: cpu_din = status;
                default:                cpu_din = pcw_pkg::IO_READ_DEFAULT;
            endcase
        end
        else
            cpu_din = ram_dout;
    end

endmodule

`default_nettype wire

/* pcw_sys_ctrl.sv */
//********************************************************************
// PCW system control top level
//********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_sys_ctrl (
    input  wire                     clk_sys,
    input  wire                     reset,
    input  wire pcw_pkg::cpu_addr_t cpu_addr,
    input  wire pcw_pkg::cpu_data_t cpu_dout,
    input  wire                     io_rd,
    input  wire                     io_wr,
    input  wire                     mem_wr,
    input  wire pcw_pkg::cpu_data_t ram_dout,
    input  wire                     vid_timer,
    input  wire                     fdc_int,
    input  wire                     iff1,
    input  wire                     vblank,
    input  wire                     ntsc,
    output pcw_pkg::cpu_data_t      cpu_din,
    output pcw_pkg::ram_addr_t      ram_addr,
    output logic                    nmi_n,
    output logic                    int_n,
    output logic                    fdc_tc,
    output logic                    motor,
    output logic                    speaker_enable,
    output pcw_pkg::cpu_data_t      roller_ptr,
    output pcw_pkg::cpu_data_t      yscroll,
    output logic                    inverse,
    output logic                    disable_vid
);

    // Page map registers
    pcw_pkg::cpu_data_t page0;
    pcw_pkg::cpu_data_t page1;
    pcw_pkg::cpu_data_t page2;
    pcw_pkg::cpu_data_t page3;
    pcw_pkg::cpu_data_t cpc_lock;

    // Disk routing from the command port
    logic disk_to_nmi;
    logic disk_to_int;
    logic int_mode_change;

    // Status path between interrupt block and read mux
    pcw_pkg::miss_count_t timer_misses;
    logic                 fdc_status;
    logic                 timer_ack;

    pcw_port_regs u_port_regs (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .io_wr           (io_wr),
        .cpu_addr        (cpu_addr),
        .cpu_dout        (cpu_dout),
        .page0           (page0),
        .page1           (page1),
        .page2           (page2),
        .page3           (page3),
        .cpc_lock        (cpc_lock),
        .roller_ptr      (roller_ptr),
        .yscroll         (yscroll),
        .inverse         (inverse),
        .disable_vid     (disable_vid),
        .disk_to_nmi     (disk_to_nmi),
        .disk_to_int     (disk_to_int),
        .int_mode_change (int_mode_change),
        .fdc_tc          (fdc_tc),
        .motor           (motor),
        .speaker_enable  (speaker_enable)
    );

    pcw_page_mapper u_page_mapper (
        .cpu_addr (cpu_addr),
        .mem_wr   (mem_wr),
        .page0    (page0),
        .page1    (page1),
        .page2    (page2),
        .page3    (page3),
        .cpc_lock (cpc_lock),
        .ram_addr (ram_addr)
    );

    pcw_int_ctrl u_int_ctrl (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .vid_timer       (vid_timer),
        .fdc_int         (fdc_int),
        .iff1            (iff1),
        .timer_ack       (timer_ack),
        .disk_to_nmi     (disk_to_nmi),
        .disk_to_int     (disk_to_int),
        .int_mode_change (int_mode_change),
        .timer_misses    (timer_misses),
        .fdc_status      (fdc_status),
        .nmi_n           (nmi_n),
        .int_n           (int_n)
    );

    pcw_bus_read_mux u_read_mux (
        .io_rd        (io_rd),
        .cpu_addr     (cpu_addr),
        .ram_dout     (ram_dout),
        .timer_misses (timer_misses),
        .fdc_status   (fdc_status),
        .vblank       (vblank),
        .ntsc         (ntsc),
        .cpu_din      (cpu_din),
        .timer_ack    (timer_ack)
    );

endmodule

`default_nettype wire

/* pcw_sys_ctrl_properties.sv */
//**********************************************************************
// Interrupt and paging properties
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module pcw_sys_ctrl_properties (
    input wire                     clk_sys,
    input wire                     reset,
    input wire pcw_pkg::cpu_addr_t cpu_addr,
    input wire pcw_pkg::ram_addr_t ram_addr,
    input wire pcw_pkg::cpu_data_t page0,
    input wire pcw_pkg::cpu_data_t page1,
    input wire pcw_pkg::cpu_data_t page2,
    input wire pcw_pkg::cpu_data_t page3,
    input wire                     nmi_n,
    input wire                     int_n,
    input wire                     motor,
    input wire                     fdc_tc,
    input wire                     speaker_enable
);

    // Page register for the current 16K slot
    pcw_pkg::cpu_data_t page_sel;

    always_comb
    begin
        case (cpu_addr[15:14])
            2'd0:    page_sel = page0;
            2'd1:    page_sel = page1;
            2'd2:    page_sel = page2;
            default: page_sel = page3;
        endcase
    end

    // NMI masks INT
    a_nmi_masks_int: assert property (@(posedge clk_sys) disable iff (reset)
        !nmi_n |-> int_n)
        else $error("INT low while NMI is active");

    a_reset_state: assert property (@(posedge clk_sys)
        reset |=> (!motor && !fdc_tc && !speaker_enable && nmi_n && int_n))
        else $error("Control outputs not idle one cycle after reset");

    // CPC banks stay in the lower 128K
    a_cpc_bank_range: assert property (@(posedge clk_sys) disable iff (reset)
        !page_sel[7] |-> !ram_addr[17])
        else $error("CPC mode produced a bank above 7");

endmodule

bind pcw_sys_ctrl pcw_sys_ctrl_properties u_props (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .cpu_addr       (cpu_addr),
    .ram_addr       (ram_addr),
    .page0          (page0),
    .page1          (page1),
    .page2          (page2),
    .page3          (page3),
    .nmi_n          (nmi_n),
    .int_n          (int_n),
    .motor          (motor),
    .fdc_tc         (fdc_tc),
    .speaker_enable (speaker_enable)
);

`default_nettype wire

/* tb_clock_gen.sv */
//**********************************************************************
// Testbench clock and reset
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_sys,
    output logic reset
);

    // 4 ns clock period
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 4;

    initial
    begin
        clk_sys = 1'b0;
        forever #HALF_PERIOD clk_sys = ~clk_sys;
    end

    // Reset released on a rising edge, like any other input
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_pcw_sys_ctrl.sv */
//**********************************************************************
// PCW system control testbench
//**********************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_pcw_sys_ctrl;

    // Bounds on the command loop and on any single wait
    localparam int MAX_COMMANDS = 500;
    localparam int MAX_WAIT     = 1000;
    localparam int TIMEOUT_NS   = 100000;

    logic                 clk_sys;
    logic                 reset;
    pcw_pkg::cpu_addr_t   cpu_addr;
    pcw_pkg::cpu_data_t   cpu_dout;
    logic                 io_rd;
    logic                 io_wr;
    logic                 mem_wr;
    pcw_pkg::cpu_data_t   ram_dout;
    logic                 vid_timer;
    logic                 fdc_int;
    logic                 iff1;
    logic                 vblank;
    logic                 ntsc;
    pcw_pkg::cpu_data_t   cpu_din;
    pcw_pkg::ram_addr_t   ram_addr;
    logic                 nmi_n;
    logic                 int_n;
    logic                 fdc_tc;
    logic                 motor;
    logic                 speaker_enable;
    pcw_pkg::cpu_data_t   roller_ptr;
    pcw_pkg::cpu_data_t   yscroll;
    logic                 inverse;
    logic                 disable_vid;

    // Failure and check counters for the closing line
    int errors;
    int checks;

    tb_clock_gen u_clock_gen (
        .clk_sys (clk_sys),
        .reset   (reset)
    );

    pcw_sys_ctrl u_dut (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .cpu_addr       (cpu_addr),
        .cpu_dout       (cpu_dout),
        .io_rd          (io_rd),
        .io_wr          (io_wr),
        .mem_wr         (mem_wr),
        .ram_dout       (ram_dout),
        .vid_timer      (vid_timer),
        .fdc_int        (fdc_int),
        .iff1           (iff1),
        .vblank         (vblank),
        .ntsc           (ntsc),
        .cpu_din        (cpu_din),
        .ram_addr       (ram_addr),
        .nmi_n          (nmi_n),
        .int_n          (int_n),
        .fdc_tc         (fdc_tc),
        .motor          (motor),
        .speaker_enable (speaker_enable),
        .roller_ptr     (roller_ptr),
        .yscroll        (yscroll),
        .inverse        (inverse),
        .disable_vid    (disable_vid)
    );

    // RAM contents seen by the CPU depend on the full address
    function automatic pcw_pkg::cpu_data_t ram_pattern(input pcw_pkg::cpu_addr_t addr);
        return addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    // Pin order follows the P command value bits from 6 down to 0
    function automatic string pin_name(input int index);
        case (index)
            6:       return "nmi_n";
            5:       return "int_n";
            4:       return "fdc_tc";
            3:       return "motor";
            2:       return "speaker_enable";
            1:       return "inverse";
            default: return "disable_vid";
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %0h, got %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic idle_cycles(input int count);
        int k;
        k = 0;
        while (k < count && k < MAX_WAIT)
        begin
            @(posedge clk_sys);
            k++;
        end
        if (count > MAX_WAIT)
        begin
            errors++;
            $display("Wait of %0d cycles is longer than the allowed limit", count);
        end
    endtask

    // I/O cycles carry a junk high address byte that the port decode ignores
    task automatic write_port(input logic [7:0] port, input pcw_pkg::cpu_data_t data);
        @(posedge clk_sys);
        cpu_addr <= {8'hA5, port};
        cpu_dout <= data;
        io_wr    <= 1'b1;
        @(posedge clk_sys);
        io_wr    <= 1'b0;
    endtask

    task automatic read_port(input logic [7:0] port, input pcw_pkg::cpu_data_t expected);
        pcw_pkg::cpu_data_t flipped;
        // Status bit 6 is vblank and bit 4 is the inverse of ntsc
        flipped = {expected[7], 1'b1, expected[5], 1'b0, expected[3:0]};
        @(posedge clk_sys);
        cpu_addr <= {8'hA5, port};
        io_rd    <= 1'b1;
        @(negedge clk_sys);
        compare_value("cpu_din", 32'(expected), 32'(cpu_din));
        @(posedge clk_sys);
        if (port == pcw_pkg::PORT_SYS_CTRL || port == pcw_pkg::PORT_CPC_LOCK)
        begin
            // Second status cycle in vblank with the NTSC strap set
            vblank <= 1'b1;
            ntsc   <= 1'b1;
            @(negedge clk_sys);
            compare_value("cpu_din", 32'(flipped), 32'(cpu_din));
            @(posedge clk_sys);
            vblank <= 1'b0;
            ntsc   <= 1'b0;
        end
        io_rd    <= 1'b0;
    endtask

    // Paging is combinational and checked mid-cycle
    task automatic access_memory(input pcw_pkg::cpu_addr_t addr, input logic write,
                                 input pcw_pkg::ram_addr_t expected);
        @(posedge clk_sys);
        cpu_addr <= addr;
        mem_wr   <= write;
        ram_dout <= ram_pattern(addr);
        @(negedge clk_sys);
        compare_value("ram_addr", 32'(expected), 32'(ram_addr));
        // Memory cycles pass RAM data straight to the CPU
        compare_value("cpu_din", 32'(ram_pattern(addr)), 32'(cpu_din));
        @(posedge clk_sys);
        mem_wr   <= 1'b0;
    endtask

    // One-cycle high pulses with random gaps between them
    task automatic apply_ticks(input int count);
        int gap;
        for (int t = 0; t < count && t < MAX_WAIT; t++)
        begin
            @(posedge clk_sys);
            vid_timer <= 1'b1;
            @(posedge clk_sys);
            vid_timer <= 1'b0;
            gap = 2 + int'($urandom % 4);
            idle_cycles(gap);
        end
        // Registered edge plus tick action
        idle_cycles(2);
    endtask

    // Only pins with a mask bit set are compared
    task automatic check_pins(input logic [6:0] mask, input logic [6:0] value);
        logic [6:0] pins;
        @(negedge clk_sys);
        pins = {nmi_n, int_n, fdc_tc, motor, speaker_enable, inverse, disable_vid};
        for (int i = 0; i < 7; i++)
        begin
            if (mask[i])
                compare_value(pin_name(i), 32'(value[i]), 32'(pins[i]));
        end
    endtask

    // Comment lines run to the next newline
    task automatic skip_line(input int fd);
        int ch;
        int n;
        ch = 0;
        n  = 0;
        while (ch != 10 && ch != -1 && n < MAX_WAIT)
        begin
            ch = $fgetc(fd);
            n++;
        end
    endtask

    task automatic run_command(input logic [7:0] op, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] c);
        case (op)
            "W": write_port(a[7:0], b[7:0]);
            "R": read_port(a[7:0], b[7:0]);
            "M": access_memory(a[15:0], b[0], c[17:0]);
            "T": apply_ticks(int'(a));
            "D": idle_cycles(int'(a));
            "P": check_pins(a[6:0], b[6:0]);
            "F":
            begin
                @(posedge clk_sys);
                fdc_int <= a[0];
                // Edge register then status latch
                idle_cycles(3);
            end
            "I":
            begin
                @(posedge clk_sys);
                iff1 <= a[0];
            end
            "E":
            begin
                @(negedge clk_sys);
                compare_value("roller_ptr", 32'(a[7:0]), 32'(roller_ptr));
                compare_value("yscroll", 32'(b[7:0]), 32'(yscroll));
            end
            default:
            begin
                errors++;
                $display("Unknown command '%c' in the test data file", op);
            end
        endcase
    endtask

    // Watchdog for the whole run
    initial
    begin
        #(TIMEOUT_NS);
        $display("Timeout: the test data did not finish in %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        int          fd;
        int          code;
        int          passes;
        int          guard;
        logic [7:0]  op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;

        errors    = 0;
        checks    = 0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        io_rd     = 1'b0;
        io_wr     = 1'b0;
        mem_wr    = 1'b0;
        ram_dout  = '0;
        vid_timer = 1'b0;
        fdc_int   = 1'b0;
        iff1      = 1'b0;
        vblank    = 1'b0;
        ntsc      = 1'b0;
        void'($urandom(83600));

        guard = 0;
        while (reset !== 1'b0 && guard < MAX_WAIT)
        begin
            @(posedge clk_sys);
            guard++;
        end
        if (reset !== 1'b0)
        begin
            errors++;
            $display("Reset was never released");
        end

        fd = $fopen("pcw_testdata.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the test data file pcw_testdata.txt");
        end
        else
        begin
            passes = 0;
            while (!$feof(fd) && passes < MAX_COMMANDS)
            begin
                passes++;
                // One letter opcode, then three hex fields
                code = $fscanf(fd, " %c", op);
                if (code == 1)
                begin
                    if (op == "#")
                        skip_line(fd);
                    else
                    begin
                        code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                        if (code != 3)
                        begin
                            errors++;
                            $display("Malformed line for command '%c' in the test data", op);
                        end
                        else
                            run_command(op, arg_a, arg_b, arg_c);
                    end
                end
            end
            if (passes >= MAX_COMMANDS)
            begin
                errors++;
                $display("Test data file has more lines than the command limit");
            end
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pcw_testdata.txt */
# op a b c, fields in hex: W port data, R port din, M addr write ram_addr, T ticks, F fdc_int,
# I iff1, D cycles, E roller yscroll, P mask value, bits {nmi_n int_n tc motor spk inv dis}
# Reset state
P 7F 63 0
M 0000 0 00000
M 4000 0 04000
M 8000 0 08000
M C000 0 0C000
R 12 FF 0
# PCW paging and video registers
W F1 85 0
M 4123 0 14123
M 4123 1 14123
W F5 3C 0
W F6 A5 0
E 3C A5 0
W F7 40 0
P 03 00 0
# CPC paging with and without the read lock
W F0 52 0
W F4 00 0
M 0010 0 14010
M 0010 1 08010
W F4 10 0
M 0010 0 08010
# System control commands, 07 and 0E are unlisted
W F8 05 0
W F8 09 0
W F8 0B 0
P 1C 1C 0
W F8 07 0
W F8 0E 0
P 1C 1C 0
W F8 06 0
P 1C 0C 0
W F8 0A 0
W F8 0C 0
P 1C 00 0
# Timer misses, saturation and delayed clear
I 1 0 0
T 3 0 0
R F8 13 0
P 60 40 0
T E 0 0
R F8 1F 0
R F4 1F 0
D 28 0 0
R F8 10 0
P 60 60 0
# Disk routing to NMI, off, then to INT
W F8 02 0
F 1 0 0
T 1 0 0
R F8 31 0
P 60 20 0
W F8 04 0
T 1 0 0
P 60 40 0
I 0 0 0
T 1 0 0
P 60 60 0
I 1 0 0
W F8 03 0
T 1 0 0
P 60 40 0
F 0 0 0
R F8 14 0

/* src.f */
pcw_pkg.sv
pcw_port_regs.sv
pcw_page_mapper.sv
pcw_int_ctrl.sv
pcw_bus_read_mux.sv
pcw_sys_ctrl.sv
pcw_sys_ctrl_properties.sv
tb_clock_gen.sv
tb_pcw_sys_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_pcw_sys_ctrl -f src.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" &&
echo "Simulation result: PASS" ||
{ echo "Simulation result: FAIL"; exit 1; }
